//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f zx_memory_core.f \
	--top-module tb_zx_memory_core \
	--Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TEST PASS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

//--- include/zx_tb_model.svh
/*
 * Reference rules for paging, mapping and the beeper.
 * Needs zx_pkg compiled first. The paging state is kept by the caller.
 */
`ifndef ZX_TB_MODEL_SVH
`define ZX_TB_MODEL_SVH

function automatic zx_pkg::cpu_data_t model_next_7ffd(input zx_pkg::machine_t m,
		input zx_pkg::cpu_addr_t a, input zx_pkg::cpu_data_t d, input zx_pkg::cpu_data_t p7);
	logic hit;
	hit = !a[15] && !a[1] && (a[14] || m != zx_pkg::MACHINE_PLUS3);
	if (m == zx_pkg::MACHINE_48 || p7[5] || !hit)
		return p7;
	return d;
endfunction

function automatic zx_pkg::cpu_data_t model_next_1ffd(input zx_pkg::machine_t m,
		input zx_pkg::cpu_addr_t a, input zx_pkg::cpu_data_t d, input zx_pkg::cpu_data_t p7,
		input zx_pkg::cpu_data_t p1);
	if (m != zx_pkg::MACHINE_PLUS3 || p7[5] || a[15:12] != 4'b0001 || a[1])
		return p1;
	return d;
endfunction

function automatic zx_pkg::phys_addr_t model_map(input zx_pkg::machine_t m,
		input zx_pkg::cpu_data_t p7, input zx_pkg::cpu_data_t p1, input zx_pkg::cpu_addr_t a);
	logic [2:0] table_pg [4][4];
	logic [2:0] pg;
	logic [1:0] slot;
	table_pg = '{'{0, 1, 2, 3}, '{4, 5, 6, 7}, '{4, 5, 6, 3}, '{4, 7, 6, 3}};
	if (m == zx_pkg::MACHINE_PLUS3 && p1[0])
		return {1'b0, table_pg[p1[2:1]][a[15:14]], a[13:0]};
	slot = (m == zx_pkg::MACHINE_48) ? 2'd1 : {(m == zx_pkg::MACHINE_PLUS3) & p1[2], p7[4]};
	pg = (a[15:14] == 2'd1) ? 3'd5 : (a[15:14] == 2'd2) ? 3'd2 : p7[2:0];
	if (a[15:14] == 2'd0)
		return {2'b10, slot, a[13:0]};
	return {1'b0, (m == zx_pkg::MACHINE_48 && a[15:14] == 2'd3) ? 3'd0 : pg, a[13:0]};
endfunction

// From the last byte written to port FE
function automatic zx_pkg::beeper_t model_beeper(input zx_pkg::cpu_data_t d);
	return (d[4] ? 16'h2000 : 16'h0000) + (d[3] ? 16'h0800 : 16'h0000);
endfunction

`endif

//--- test/tb_zx_memory_core.sv
`timescale 1ns/1ps
/*
 * Testbench for the Spectrum memory and I/O core.
 * Random stimulus from a fixed seed, checked against the include/ model.
 * The RAM model answers after 0 to 3 cycles with data derived from the address.
 */
module tb_zx_memory_core;
	import zx_pkg::*;

	`include "zx_tb_model.svh"

	localparam int WAIT_LIMIT = 50;

	logic       clk_sys;
	logic       reset;
	machine_t   machine_sel;
	logic       req_valid;
	logic       req_ready;
	logic       req_write;
	logic       req_io;
	cpu_addr_t  req_addr;
	cpu_data_t  req_wdata;
	logic       rsp_valid;
	cpu_data_t  rsp_rdata;
	logic       ram_valid;
	logic       ram_ready;
	logic       ram_we;
	phys_addr_t ram_addr;
	cpu_data_t  ram_wdata;
	cpu_data_t  ram_rdata;
	logic [2:0] border;
	beeper_t    beeper;

	integer seed;
	integer ram_seed;
	int     ram_delay;
	int     checks;
	int     errors;
	int     test_base;

	// Reference state
	machine_t   m_machine;
	cpu_data_t  m_7ffd;
	cpu_data_t  m_1ffd;
	logic [2:0] m_border;
	beeper_t    m_beeper;

	zx_memory_core DUT (.*);

	always #50 clk_sys = ~clk_sys;

	// ====================
	// RAM responder
	// ====================
	always @(posedge clk_sys) begin
		#1;
		if (ram_ready) begin
			ram_ready = 1'b0;
			ram_delay = $random(ram_seed) & 3;
		end else if (ram_valid) begin
			if (ram_delay == 0) begin
				ram_ready = 1'b1;
				ram_rdata = ram_addr[7:0] ^ ram_addr[17:10];
			end else begin
				ram_delay--;
			end
		end
	end

	task automatic check(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("[FAIL] %0t ns: %s", $time, msg);
		end
	endtask

	task automatic abort_timeout(input string what);
		$display("Timeout: %s did not arrive at %0t ns", what, $time);
		$display("TEST FAIL");
		$finish;
	endtask

	task automatic end_test(input string name);
		$display("%s finished with %0d errors", name, errors - test_base);
		test_base = errors;
	endtask

	task automatic apply_reset(input machine_t m);
		@(posedge clk_sys);
		#1;
		reset       = 1'b1;
		machine_sel = m;
		req_valid   = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1;
		check(!req_ready && !rsp_valid && !ram_valid, "outputs not idle in reset");
		reset     = 1'b0;
		m_machine = m;
		m_7ffd    = '0;
		m_1ffd    = '0;
		m_border  = '0;
		m_beeper  = '0;
	endtask

	// One CPU request with the outputs sampled on falling edges
	task automatic bus_access(input logic wr, input logic io, input cpu_addr_t a,
			input cpu_data_t d, output cpu_data_t rd, output logic saw_ram,
			output phys_addr_t seen_addr, output logic seen_we);
		int n;
		@(posedge clk_sys);
		#1;
		req_valid = 1'b1;
		req_write = wr;
		req_io    = io;
		req_addr  = a;
		req_wdata = d;
		n = 0;
		@(negedge clk_sys);
		while (!req_ready) begin
			n++;
			if (n > WAIT_LIMIT)
				abort_timeout("req_ready");
			@(negedge clk_sys);
		end
		@(posedge clk_sys);
		#1;
		req_valid = 1'b0;
		saw_ram   = 1'b0;
		seen_addr = '0;
		seen_we   = 1'b0;
		n = 0;
		@(negedge clk_sys);
		while (!rsp_valid) begin
			if (ram_valid) begin
				saw_ram   = 1'b1;
				seen_addr = ram_addr;
				seen_we   = ram_we;
				if (ram_we)
					check(ram_wdata == d, "ram_wdata differs from request data");
			end
			n++;
			if (n > WAIT_LIMIT)
				abort_timeout("rsp_valid");
			@(negedge clk_sys);
		end
		rd = rsp_rdata;
	endtask

	task automatic mem_access(input logic wr, input cpu_addr_t a, input cpu_data_t d);
		phys_addr_t exp;
		phys_addr_t seen;
		cpu_data_t  rd;
		logic       saw;
		logic       we;
		exp = model_map(m_machine, m_7ffd, m_1ffd, a);
		bus_access(wr, 1'b0, a, d, rd, saw, seen, we);
		// ROM writes never reach RAM
		if (wr && exp[17]) begin
			check(!saw, $sformatf("ROM write to %h reached RAM", a));
		end else begin
			check(saw, $sformatf("no RAM cycle for %h", a));
			check(seen == exp, $sformatf("addr %h mapped to %h, expected %h", a, seen, exp));
			check(we == wr, $sformatf("ram_we wrong for %h", a));
		end
		if (!wr)
			check(rd == (exp[7:0] ^ exp[17:10]), $sformatf("read %h returned %h", a, rd));
	endtask

	task automatic io_write(input cpu_addr_t a, input cpu_data_t d);
		cpu_data_t  rd;
		cpu_data_t  n7;
		phys_addr_t seen;
		logic       saw;
		logic       we;
		bus_access(1'b1, 1'b1, a, d, rd, saw, seen, we);
		check(!saw, "IO write started a RAM cycle");
		n7     = model_next_7ffd(m_machine, a, d, m_7ffd);
		m_1ffd = model_next_1ffd(m_machine, a, d, m_7ffd, m_1ffd);
		m_7ffd = n7;
		if (!a[0]) begin
			m_border = d[2:0];
			m_beeper = model_beeper(d);
		end
		// Registers load on the first edge and the beeper on the second
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check(border == m_border, $sformatf("border %0d, expected %0d", border, m_border));
		check(beeper == m_beeper, $sformatf("beeper %h, expected %h", beeper, m_beeper));
	endtask

	task automatic read_quads();
		logic [31:0] rnd;
		logic [1:0]  qv;
		for (int q = 0; q < 4; q++) begin
			rnd = $random(seed);
			qv  = q[1:0];
			mem_access(1'b0, {qv, rnd[13:0]}, 8'h00);
		end
	endtask

	initial begin
		logic [31:0] rnd;
		cpu_data_t   rd;
		phys_addr_t  seen;
		logic        saw;
		logic        we;
		seed        = 32'hcb5c44ea;
		ram_seed    = seed + 1;
		ram_delay   = 0;
		checks      = 0;
		errors      = 0;
		test_base   = 0;
		clk_sys     = 1'b0;
		reset       = 1'b1;
		machine_sel = MACHINE_128;
		req_valid   = 1'b0;
		req_write   = 1'b0;
		req_io      = 1'b0;
		req_addr    = '0;
		req_wdata   = '0;
		ram_ready   = 1'b0;
		ram_rdata   = '0;

		// ====================
		// 128K machine
		// ====================
		apply_reset(MACHINE_128);
		for (int i = 0; i < 10; i++) begin
			rnd = $random(seed);
			io_write(16'h7FFD, rnd[7:0] & 8'hDF);
			read_quads();
		end
		end_test("128K paging");

		io_write(16'h7FFD, 8'h23);
		for (int i = 0; i < 5; i++) begin
			rnd = $random(seed);
			io_write(16'h7FFD, rnd[7:0]);
			read_quads();
		end
		end_test("7FFD lock");

		// ====================
		// +3 machine
		// ====================
		apply_reset(MACHINE_PLUS3);
		for (int i = 0; i < 12; i++) begin
			rnd = $random(seed);
			if (rnd[8])
				io_write(16'h7FFD, rnd[7:0] & 8'hDF);
			else
				io_write(16'h1FFD, rnd[7:0]);
			read_quads();
		end
		for (int cfg = 0; cfg < 4; cfg++) begin
			io_write(16'h1FFD, 8'(cfg * 2 + 1));
			read_quads();
		end
		end_test("+3 paging");

		io_write(16'h1FFD, 8'h04);
		mem_access(1'b1, 16'h0100, 8'h5A);
		mem_access(1'b1, 16'h3FFF, 8'hA5);
		io_write(16'h1FFD, 8'h03);
		mem_access(1'b1, 16'h0100, 8'h5A);
		mem_access(1'b1, 16'h3FFF, 8'hA5);
		end_test("ROM write suppression");

		// ====================
		// 48K machine
		// ====================
		apply_reset(MACHINE_48);
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			io_write(16'h7FFD, rnd[7:0]);
			read_quads();
		end
		bus_access(1'b0, 1'b0, 16'h0123, 8'h00, rd, saw, seen, we);
		check(seen[17:14] == 4'b1001, $sformatf("48K ROM address %h is not slot 1", seen));
		end_test("48K mapping");

		for (int i = 0; i < 12; i++) begin
			rnd = $random(seed);
			io_write({rnd[31:17], rnd[16] & rnd[15]}, rnd[7:0]);
			bus_access(1'b0, 1'b1, rnd[23:8], 8'h00, rd, saw, seen, we);
			check(rd == 8'hFF, $sformatf("IO read returned %h", rd));
		end
		end_test("Port FE");

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- verilog/zx_addr_map.sv
`timescale 1ns/1ps
/*
 * Pure combinational CPU to physical address mapping.
 * The special all-RAM modes apply on +3 only and then nothing is ROM.
 */
module zx_addr_map (
	input  zx_pkg::cpu_addr_t  cpu_addr,
	input  zx_pkg::cpu_data_t  page_7ffd,
	input  zx_pkg::cpu_data_t  page_1ffd,
	input  zx_pkg::machine_t   machine,
	output zx_pkg::phys_addr_t phys_addr,
	output logic               is_rom
);
	import zx_pkg::*;

	logic [1:0] quad;
	logic       special;
	rom_slot_t  rom_slot;
	ram_page_t  ram_page;

	// Pages for 1FFD bits 2..1 = 0..3 give 0123, 4567, 4563 and 4763
	function automatic ram_page_t special_page(input logic [1:0] cfg, input logic [1:0] q);
		ram_page_t page;
		page = {|cfg, q};
		if (cfg[1] && q == 2'd3)
			page = 3'd3;
		if (cfg == 2'd3 && q == 2'd1)
			page = 3'd7;
		return page;
	endfunction

	assign quad    = cpu_addr[15:14];
	assign special = (machine == MACHINE_PLUS3) && page_1ffd[SPECIAL_BIT];
	assign is_rom  = !special && (quad == 2'd0);

	always_comb begin
		case (machine)
			MACHINE_48:    rom_slot = ROM_SLOT_48;
			MACHINE_PLUS3: rom_slot = {page_1ffd[ROM_HI_BIT], page_7ffd[ROM_SEL_BIT]};
			default:       rom_slot = {1'b0, page_7ffd[ROM_SEL_BIT]};
		endcase
	end

	always_comb begin
		if (special) begin
			ram_page = special_page(page_1ffd[2:1], quad);
		end else begin
			case (quad)
				2'd1:    ram_page = PAGE_Q1;
				2'd2:    ram_page = PAGE_Q2;
				2'd3:    ram_page = (machine == MACHINE_48) ? 3'd0 : page_7ffd[2:0];
				// Quadrant 0 is ROM here, page unused
				default: ram_page = 3'd0;
			endcase
		end
	end

	assign phys_addr = is_rom ? {1'b1, 1'b0, rom_slot, cpu_addr[13:0]}
	                          : {1'b0, ram_page, cpu_addr[13:0]};

endmodule

//--- verilog/zx_bus_ctrl.sv
`timescale 1ns/1ps
/*
 * One CPU request at a time. req_ready is low while a request is in flight.
 * The response has no back-pressure, so rsp_valid is a single-cycle pulse.
 * A write that maps to ROM is answered without a RAM cycle.
 */
module zx_bus_ctrl (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               req_valid,
	output logic               req_ready,
	input  logic               req_write,
	input  logic               req_io,
	input  zx_pkg::cpu_addr_t  req_addr,
	input  zx_pkg::cpu_data_t  req_wdata,
	output logic               rsp_valid,
	output zx_pkg::cpu_data_t  rsp_rdata,
	output logic               ram_valid,
	input  logic               ram_ready,
	output logic               ram_we,
	output zx_pkg::phys_addr_t ram_addr,
	output zx_pkg::cpu_data_t  ram_wdata,
	input  zx_pkg::cpu_data_t  ram_rdata,
	input  zx_pkg::phys_addr_t phys_addr,
	input  logic               is_rom,
	output logic               io_wr_stb,
	output zx_pkg::cpu_addr_t  io_addr,
	output zx_pkg::cpu_data_t  io_wdata
);
	import zx_pkg::*;

	bus_state_t state;
	bus_state_t state_next;
	logic       lat_write;
	cpu_addr_t  lat_addr;
	cpu_data_t  lat_wdata;
	cpu_data_t  rdata_q;
	logic       accept;
	logic       rom_write;

	assign accept    = req_valid && req_ready;
	assign rom_write = lat_write && is_rom;

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: if (accept) state_next = req_io ? ST_IO : ST_MEM;
			ST_IO:   state_next = ST_IDLE;
			ST_MEM: begin
				if (rom_write)
					state_next = ST_IDLE;
				else if (ram_ready)
					state_next = ST_RESP;
			end
			default: state_next = ST_IDLE;
		endcase
	end

	// Ready is registered so it returns together with the idle state
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= ST_IDLE;
			req_ready <= 1'b0;
			lat_write <= 1'b0;
		end else begin
			state     <= state_next;
			req_ready <= (state_next == ST_IDLE);
			if (accept)
				lat_write <= req_write;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			lat_addr  <= req_addr;
			lat_wdata <= req_wdata;
		end
		if (ram_valid && ram_ready)
			rdata_q <= ram_rdata;
	end

	// ====================
	// Outputs
	// ====================
	assign rsp_valid = (state == ST_IO) || (state == ST_RESP) || ((state == ST_MEM) && rom_write);
	assign rsp_rdata = (state == ST_RESP) ? rdata_q : IO_READ_VALUE;

	// Held until the RAM takes it, address comes from the mapper
	assign ram_valid = (state == ST_MEM) && !rom_write;
	assign ram_we    = ram_valid && lat_write;
	assign ram_addr  = phys_addr;
	assign ram_wdata = lat_wdata;

	assign io_wr_stb = (state == ST_IO) && lat_write;
	assign io_addr   = lat_addr;
	assign io_wdata  = lat_wdata;

endmodule

//--- verilog/zx_memory_core.sv
`timescale 1ns/1ps
/*
 * Memory and I/O core of a 128K / +2A / +3 Spectrum.
 * machine_sel is sampled only while reset is high. IO reads always return FF.
 */
module zx_memory_core (
	input  logic               clk_sys,
	input  logic               reset,
	input  zx_pkg::machine_t   machine_sel,
	input  logic               req_valid,
	output logic               req_ready,
	input  logic               req_write,
	input  logic               req_io,
	input  zx_pkg::cpu_addr_t  req_addr,
	input  zx_pkg::cpu_data_t  req_wdata,
	output logic               rsp_valid,
	output zx_pkg::cpu_data_t  rsp_rdata,
	output logic               ram_valid,
	input  logic               ram_ready,
	output logic               ram_we,
	output zx_pkg::phys_addr_t ram_addr,
	output zx_pkg::cpu_data_t  ram_wdata,
	input  zx_pkg::cpu_data_t  ram_rdata,
	output logic [2:0]         border,
	output zx_pkg::beeper_t    beeper
);
	import zx_pkg::*;

	logic       io_wr_stb;
	cpu_addr_t  io_addr;
	cpu_data_t  io_wdata;
	cpu_data_t  page_7ffd;
	cpu_data_t  page_1ffd;
	machine_t   machine;
	phys_addr_t phys_addr;
	logic       is_rom;

	zx_bus_ctrl u_bus_ctrl (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req_write (req_write),
		.req_io    (req_io),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.rsp_valid (rsp_valid),
		.rsp_rdata (rsp_rdata),
		.ram_valid (ram_valid),
		.ram_ready (ram_ready),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata),
		.phys_addr (phys_addr),
		.is_rom    (is_rom),
		.io_wr_stb (io_wr_stb),
		.io_addr   (io_addr),
		.io_wdata  (io_wdata)
	);

	zx_paging_regs u_paging_regs (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.machine_sel (machine_sel),
		.io_wr_stb   (io_wr_stb),
		.io_addr     (io_addr),
		.io_wdata    (io_wdata),
		.page_7ffd   (page_7ffd),
		.page_1ffd   (page_1ffd),
		.machine     (machine)
	);

	// Mapper sees the latched request address
	zx_addr_map u_addr_map (
		.cpu_addr  (io_addr),
		.page_7ffd (page_7ffd),
		.page_1ffd (page_1ffd),
		.machine   (machine),
		.phys_addr (phys_addr),
		.is_rom    (is_rom)
	);

	zx_ula_port u_ula_port (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_wr_stb (io_wr_stb),
		.io_addr   (io_addr),
		.io_wdata  (io_wdata),
		.border    (border),
		.beeper    (beeper)
	);

endmodule

//--- verilog/zx_paging_regs.sv
`timescale 1ns/1ps
/*
 * 7FFD and 1FFD paging registers.
 * The machine type is taken from machine_sel only while reset is high.
 * The 7FFD lock bit blocks both registers until the next reset.
 * 48K never pages.
 */
module zx_paging_regs (
	input  logic              clk_sys,
	input  logic              reset,
	input  zx_pkg::machine_t  machine_sel,
	input  logic              io_wr_stb,
	input  zx_pkg::cpu_addr_t io_addr,
	input  zx_pkg::cpu_data_t io_wdata,
	output zx_pkg::cpu_data_t page_7ffd,
	output zx_pkg::cpu_data_t page_1ffd,
	output zx_pkg::machine_t  machine
);
	import zx_pkg::*;

	logic is_plus3;
	logic locked;
	logic sel_7ffd;
	logic sel_1ffd;

	assign is_plus3 = (machine == MACHINE_PLUS3);
	assign locked   = (machine == MACHINE_48) || page_7ffd[PAGE_LOCK_BIT];

	// ====================
	// Port decode
	// ====================
	// 128K decodes A15 and A1 only, +3 also needs A14
	always_comb begin
		sel_7ffd = !io_addr[15] && !io_addr[1];
		if (is_plus3)
			sel_7ffd = sel_7ffd && io_addr[14];
	end

	// 1FFD exists on +3 only
	assign sel_1ffd = is_plus3 && (io_addr[15:12] == PORT_1FFD_TOP) && !io_addr[1];

	// ====================
	// Registers
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			machine   <= machine_sel;
			page_7ffd <= '0;
			page_1ffd <= '0;
		end else if (io_wr_stb && !locked) begin
			if (sel_7ffd)
				page_7ffd <= io_wdata;
			else if (sel_1ffd)
				page_1ffd <= io_wdata;
		end
	end

endmodule

//--- verilog/zx_pkg.sv
/*
 * Shared types and constants for the Spectrum memory and I/O core.
 * Physical addresses are 18 bits. Bit 17 marks ROM, and ROM slots use bits 15..14.
 * Only 48K, 128K/+2 and +2A/+3 machines are modelled.
 */
package zx_pkg;

	// ====================
	// Bus widths
	// ====================
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;
	typedef logic [17:0] phys_addr_t;
	typedef logic [2:0]  ram_page_t;
	typedef logic [1:0]  rom_slot_t;
	typedef logic [15:0] beeper_t;

	typedef enum logic [1:0] {
		MACHINE_48,
		MACHINE_128,
		MACHINE_PLUS3
	} machine_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_IO,
		ST_MEM,
		ST_RESP
	} bus_state_t;

	// ====================
	// Paging register bits
	// ====================
	localparam int PAGE_LOCK_BIT = 5;
	localparam int ROM_SEL_BIT   = 4;
	localparam int SPECIAL_BIT   = 0;
	// 1FFD bit 2, high half of the +3 ROM slot
	localparam int ROM_HI_BIT    = 2;

	// Port decode
	localparam logic [3:0] PORT_1FFD_TOP = 4'b0001;
	localparam int         ULA_PORT_BIT  = 0;

	// Fixed pages of the normal layout
	localparam ram_page_t PAGE_Q1     = 3'd5;
	localparam ram_page_t PAGE_Q2     = 3'd2;
	localparam rom_slot_t ROM_SLOT_48 = 2'd1;

	// Beeper mix and idle bus value
	localparam beeper_t   EAR_WEIGHT    = 16'h2000;
	localparam beeper_t   MIC_WEIGHT    = 16'h0800;
	localparam cpu_data_t IO_READ_VALUE = 8'hFF;

endpackage

//--- verilog/zx_ula_port.sv
`timescale 1ns/1ps
/*
 * ULA port FE, write side only. Any even port address selects it.
 * The beeper sample is unsigned and lags the EAR/MIC bits by one clock.
 */
module zx_ula_port (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              io_wr_stb,
	input  zx_pkg::cpu_addr_t io_addr,
	input  zx_pkg::cpu_data_t io_wdata,
	output logic [2:0]        border,
	output zx_pkg::beeper_t   beeper
);
	import zx_pkg::*;

	logic ear;
	logic mic;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border <= 3'd0;
			ear    <= 1'b0;
			mic    <= 1'b0;
			beeper <= '0;
		end else begin
			if (io_wr_stb && !io_addr[ULA_PORT_BIT]) begin
				border <= io_wdata[2:0];
				ear    <= io_wdata[4];
				mic    <= io_wdata[3];
			end
			// EAR dominates, MIC is a quieter click
			beeper <= (ear ? EAR_WEIGHT : '0) + (mic ? MIC_WEIGHT : '0);
		end
	end

endmodule

//--- zx_memory_core.f
+incdir+include
verilog/zx_pkg.sv
verilog/zx_bus_ctrl.sv
verilog/zx_paging_regs.sv
verilog/zx_addr_map.sv
verilog/zx_ula_port.sv
verilog/zx_memory_core.sv
test/tb_zx_memory_core.sv
